// ==== common/maxMetricPkg.sv ====
package maxMetricPkg;

   // trellis size
   localparam int numStates = 64;
   localparam int indexBits = 6;      // enough for state 63

   // datapath widths in two's complement
   localparam int metricBits = 12;    // accumulated path metric
   localparam int branchBits = 8;     // per-symbol branch metric

   typedef logic signed [metricBits-1:0] metric_t;
   typedef logic signed [branchBits-1:0] branch_t;
   typedef logic [indexBits-1:0]         stateIdx_t;

   // saturation limits of an accumulated metric
   localparam metric_t metricMin = {1'b1, {(metricBits-1){1'b0}}};
   localparam metric_t metricMax = {1'b0, {(metricBits-1){1'b1}}};

   // one entry of the max tree
   // the state index rides along with its metric, so no index muxing
   // is needed after the last compare stage
   typedef struct packed {
      metric_t   value;
      stateIdx_t index;
   } candidate_t;

endpackage

// ==== hw/comp4Max.sv ====
`timescale 1ns/1ps

// four-input signed maximum with one register stage
module comp4Max
   import maxMetricPkg::*;
(
   input  logic       clk,
   input  candidate_t a,
   input  candidate_t b,
   input  candidate_t c,
   input  candidate_t d,
   output candidate_t best
);

   candidate_t winAB;     // first half
   candidate_t winCD;     // second half
   candidate_t winAll;

   // y replaces x on a larger value
   // on equal values the higher state index is kept
   function automatic candidate_t pickMax(candidate_t x, candidate_t y);
      logic valueGreater;
      logic valueEqual;
      logic indexGreater;
      valueGreater = (y.value > x.value);   // signed compare
      valueEqual   = (y.value == x.value);
      indexGreater = (y.index > x.index);
      if (valueGreater || (valueEqual && indexGreater))
         return y;
      else
         return x;
   endfunction

   // two pairs in parallel and then the final pick
   always_comb begin
      winAB  = pickMax(a, b);
      winCD  = pickMax(c, d);
      winAll = pickMax(winAB, winCD);
   end

   // new set accepted every cycle
   always_ff @(posedge clk) begin
      best <= winAll;
   end

endmodule

// ==== maxTree/maxMetricTree.sv ====
`timescale 1ns/1ps

// argmax over all state metrics
// 64 -> 16 -> 4 -> 1 with one register per stage and 3 cycles total
module maxMetricTree
   import maxMetricPkg::*;
(
   input  logic                    clk,
   input  metric_t [numStates-1:0] metrics,
   output candidate_t              winner
);

   localparam int s1Cells = numStates / 4;   // 16 cells in stage one
   localparam int s2Cells = s1Cells / 4;     // 4 cells in stage two

   candidate_t leafCand [numStates];  // metric plus own state index
   candidate_t s1Best [s1Cells];
   candidate_t s2Best [s2Cells];

   genvar i;

   generate
      // attach the state number to each metric
      for (i = 0; i < numStates; i++) begin : gTag
         assign leafCand[i] = '{value: metrics[i], index: stateIdx_t'(i)};
      end

      // each stage one cell sees four neighbouring states
      for (i = 0; i < s1Cells; i++) begin : gStage1
         comp4Max uComp (
            .clk  (clk),
            .a    (leafCand[4*i]),
            .b    (leafCand[4*i+1]),
            .c    (leafCand[4*i+2]),
            .d    (leafCand[4*i+3]),
            .best (s1Best[i])
         );
      end

      // stage two gives the winners of 16 states each
      for (i = 0; i < s2Cells; i++) begin : gStage2
         comp4Max uComp (
            .clk  (clk),
            .a    (s1Best[4*i]),
            .b    (s1Best[4*i+1]),
            .c    (s1Best[4*i+2]),
            .d    (s1Best[4*i+3]),
            .best (s2Best[i])
         );
      end
   endgenerate

   // final compare
   // inputs keep ascending index order, so the tie rule holds end to end
   comp4Max uStage3 (
      .clk  (clk),
      .a    (s2Best[0]),
      .b    (s2Best[1]),
      .c    (s2Best[2]),
      .d    (s2Best[3]),
      .best (winner)
   );

endmodule

// ==== hw/metricBank.sv ====
`timescale 1ns/1ps

// accumulated path metrics of all trellis states
module metricBank
   import maxMetricPkg::*;
(
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    symEn,
   input  branch_t [numStates-1:0] branchMetrics,
   input  metric_t                 normVal,
   output metric_t [numStates-1:0] metrics
);

   // two guard bits hold old + branch - norm without overflow
   localparam int sumBits = metricBits + 2;

   typedef logic signed [sumBits-1:0] sum_t;

   sum_t    [numStates-1:0] rawSum;        // before clamping
   metric_t [numStates-1:0] nextMetrics;

   // clamp a wide sum back into the metric range
   function automatic metric_t satMetric(sum_t sum);
      metric_t result;
      if (sum < sum_t'(metricMin))
         result = metricMin;
      else if (sum > sum_t'(metricMax))
         result = metricMax;
      else
         result = metric_t'(sum);
      return result;
   endfunction

   // add branch, subtract last best metric
   // keeps the winning path close to zero
   always_comb begin
      for (int s = 0; s < numStates; s++) begin
         rawSum[s] = sum_t'(metrics[s])
                   + sum_t'(branchMetrics[s])    // sign extended
                   - sum_t'(normVal);
         nextMetrics[s] = satMetric(rawSum[s]);
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         metrics <= '0;
      end else if (symEn) begin
         metrics <= nextMetrics;   // one update per symbol
      end
   end

endmodule

// ==== hw/maxMetricTop.sv ====
`timescale 1ns/1ps

// survivor metric section
// bank -> max tree -> result register with maxVal fed back for normalization
module maxMetricTop
   import maxMetricPkg::*;
(
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    symEn,
   input  branch_t [numStates-1:0] branchMetrics,
   output logic [indexBits-1:0]    index,
   output metric_t                 maxVal,
   output logic                    symEnDly
);

   metric_t [numStates-1:0] metrics;
   candidate_t              winner;

   // strobe follows the data
   // bit 0 marks fresh metrics and bits 1..3 the three tree stages
   logic [3:0] strobePipe;

   metricBank uBank (
      .clk           (clk),
      .reset         (reset),
      .symEn         (symEn),
      .branchMetrics (branchMetrics),
      .normVal       (maxVal),      // last symbol's best metric
      .metrics       (metrics)
   );

   maxMetricTree uTree (
      .clk     (clk),
      .metrics (metrics),
      .winner  (winner)
   );

   always_ff @(posedge clk) begin
      if (reset) begin
         strobePipe <= '0;
         symEnDly   <= 1'b0;
         index      <= '0;
         maxVal     <= '0;
      end else begin
         strobePipe <= {strobePipe[2:0], symEn};
         symEnDly   <= strobePipe[3];
         // winner is only meaningful when the strobe arrives with it
         if (strobePipe[3]) begin
            index  <= winner.index;
            maxVal <= winner.value;
         end
      end
   end

endmodule

// ==== test/maxMetricModel.svh ====
`ifndef MAX_METRIC_MODEL_SVH
`define MAX_METRIC_MODEL_SVH

// reference model of the metric bank and the argmax

// metric range of a two's complement word of metricBits
localparam int modelMin = -(2 ** (metricBits - 1));
localparam int modelMax = (2 ** (metricBits - 1)) - 1;

int symBranch [numStates];                      // branch metrics of the current symbol
int modelMetrics [numStates] = '{default: 0};   // all zero after reset
int modelMaxVal = 0;                            // last reported best used as normVal
int modelIndex = 0;
int errorCount = 0;

function automatic int clampMetric(int sum);
   if (sum < modelMin)
      return modelMin;
   if (sum > modelMax)
      return modelMax;
   return sum;
endfunction

// metric of a state after normalization but before the branch is added
function automatic int baseMetric(int s);
   return modelMetrics[s] - modelMaxVal;
endfunction

// per symbol add branch, subtract last best and clamp, then take the argmax
function automatic void modelUpdate();
   int best;
   int bestIdx;
   for (int s = 0; s < numStates; s++) begin
      modelMetrics[s] = clampMetric(modelMetrics[s] + symBranch[s] - modelMaxVal);
   end
   best = modelMetrics[0];
   bestIdx = 0;
   for (int s = 1; s < numStates; s++) begin
      if (modelMetrics[s] >= best) begin   // >= so the higher index wins a tie
         best = modelMetrics[s];
         bestIdx = s;
      end
   end
   modelMaxVal = best;
   modelIndex = bestIdx;
endfunction

task automatic checkValue(input string name, input int expected, input int actual);
   if (expected != actual) begin
      errorCount++;
      $display("MISMATCH at %0t ns: %s expected %0d, actual %0d",
               $time, name, expected, actual);
   end
endtask

`endif

// ==== test/maxMetricTb.sv ====
`timescale 1ns/1ps

module maxMetricTb
   import maxMetricPkg::*;
();

   localparam int numSymbols = 200;
   localparam int dlyLatency = 4;      // symEn edge to symEnDly edge
   localparam int waitLimit = 20;
   localparam int minGap = 5;
   localparam int satFirst = 100;      // symbols with clamped states
   localparam int satLast = 139;
   localparam int satStates = 8;       // states 0..7 get the lowest branch
   localparam int tieReach = -100;     // second tie state must be this close to the best
   localparam int branchLow = -(2 ** (branchBits - 1));
   localparam int branchHigh = (2 ** (branchBits - 1)) - 1;

   logic                    clk;
   logic                    reset;
   logic                    symEn;
   branch_t [numStates-1:0] branchMetrics;
   logic [indexBits-1:0]    index;
   metric_t                 maxVal;
   logic                    symEnDly;

   logic [15:0] lfsrState = 16'd20704;
   int pulseCount = 0;
   int symbolsSent = 0;
   bit prevDly = 1'b0;
   bit aborted = 1'b0;
   bit tieActive = 1'b0;
   int tieHigh = 0;

   `include "maxMetricModel.svh"

   maxMetricTop dut (
      .clk           (clk),
      .reset         (reset),
      .symEn         (symEn),
      .branchMetrics (branchMetrics),
      .index         (index),
      .maxVal        (maxVal),
      .symEnDly      (symEnDly)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // galois LFSR with taps 16,14,13,11
   function automatic bit stepLfsr();
      bit lsb;
      lsb = lfsrState[0];
      lfsrState = lfsrState >> 1;
      if (lsb)
         lfsrState = lfsrState ^ 16'hB400;
      return lsb;
   endfunction

   function automatic int takeBits(int count);
      int result;
      result = 0;
      for (int i = 0; i < count; i++)
         result = result * 2 + (stepLfsr() ? 1 : 0);
      return result;
   endfunction

   function automatic int takeBranch();
      int v;
      v = takeBits(branchBits);
      if (v > branchHigh)
         v = v - (2 ** branchBits);   // two's complement
      return v;
   endfunction

   function automatic bit inSatWindow(int n);
      return (n >= satFirst) && (n <= satLast);
   endfunction

   // branch metrics of symbol n including the forced tie and saturation cases
   function automatic void buildStimulus(int n);
      int common;
      int p;
      int q;
      int start;
      int cand;
      common = takeBranch();
      tieActive = 1'b0;
      for (int s = 0; s < numStates; s++)
         symBranch[s] = (n % 16 == 0) ? common : takeBranch();
      if ((n % 16 == 8) && !inSatWindow(n)) begin
         p = modelIndex;   // last winner has base metric 0
         q = -1;
         start = takeBits(indexBits);
         for (int k = 0; k < numStates; k++) begin
            cand = (start + k) % numStates;
            if (q < 0 && cand != p && baseMetric(cand) >= tieReach)
               q = cand;
         end
         if (q >= 0) begin
            for (int s = 0; s < numStates; s++)
               symBranch[s] = branchLow;
            symBranch[p] = branchHigh + baseMetric(q);   // both land on the same value
            symBranch[q] = branchHigh;
            tieHigh = (p > q) ? p : q;
            tieActive = 1'b1;
         end
      end
      if (inSatWindow(n)) begin
         for (int s = 0; s < satStates; s++)
            symBranch[s] = branchLow;
      end
   endfunction

   task automatic checkSaturation();
      for (int s = 0; s < satStates; s++) begin
         if (modelMetrics[s] != modelMin) begin
            $display("ERROR at %0t ns: state %0d never reached the saturation floor",
                     $time, s);
            errorCount++;
         end
         checkValue($sformatf("bank metric %0d", s), modelMetrics[s],
                    int'(dut.uBank.metrics[s]));
      end
   endtask

   // counts every symEnDly pulse, flags pulses wider than one cycle
   initial begin
      forever begin
         @(negedge clk);
         if (symEnDly) begin
            pulseCount++;
            if (prevDly) begin
               $display("ERROR at %0t ns: symEnDly stayed high for a second cycle", $time);
               errorCount++;
            end
         end
         prevDly = symEnDly;
      end
   end

   initial begin
      int waitCycles;
      int gap;
      bit dlySeen;
      reset <= 1'b1;
      symEn <= 1'b0;
      branchMetrics <= '0;
      repeat (10) @(posedge clk);
      reset <= 1'b0;

      // outputs quiet after reset
      repeat (3) begin
         @(negedge clk);
         checkValue("index after reset", 0, int'(index));
         checkValue("maxVal after reset", 0, int'(maxVal));
         checkValue("symEnDly after reset", 0, int'(symEnDly));
      end
      checkValue("symEnDly pulses before first symEn", 0, pulseCount);

      for (int n = 0; n < numSymbols && !aborted; n++) begin
         buildStimulus(n);
         @(posedge clk);
         symEn <= 1'b1;
         for (int s = 0; s < numStates; s++)
            branchMetrics[s] <= branch_t'(symBranch[s]);
         modelUpdate();
         symbolsSent++;
         @(posedge clk);   // DUT samples the strobe here
         symEn <= 1'b0;

         dlySeen = 1'b0;
         waitCycles = 0;
         while (!dlySeen && !aborted) begin
            @(negedge clk);
            if (symEnDly) begin
               dlySeen = 1'b1;
            end else if (waitCycles == waitLimit) begin
               $display("ERROR at %0t ns: no symEnDly within %0d cycles of symbol %0d",
                        $time, waitLimit, n);
               errorCount++;
               aborted = 1'b1;
            end else begin
               waitCycles++;
            end
         end

         if (!aborted) begin
            checkValue("symEnDly latency", dlyLatency, waitCycles);
            checkValue("index", modelIndex, int'(index));
            checkValue("maxVal", modelMaxVal, int'(maxVal));
            if (n == 0)
               checkValue("index on all-equal metrics", numStates - 1, int'(index));
            if (tieActive)
               checkValue("index on two-state tie", tieHigh, int'(index));
            if (int'(maxVal) < branchLow || int'(maxVal) > branchHigh) begin
               $display("ERROR at %0t ns: maxVal %0d drifted outside the branch metric range",
                        $time, int'(maxVal));
               errorCount++;
            end
            if (n == satLast)
               checkSaturation();
            gap = minGap + takeBits(3);   // 5 to 12 idle cycles
            repeat (gap - minGap) @(negedge clk);
         end
      end

      repeat (8) @(negedge clk);   // room for a stray late pulse
      checkValue("symEnDly pulse count", symbolsSent, pulseCount);
      $display("symbols %0d, errors %0d", symbolsSent, errorCount);
      if (errorCount == 0)
         $display("Testbench passed");
      else
         $display("Testbench failed");
      $finish;
   end

endmodule

// ==== filelist.f ====
+incdir+test
common/maxMetricPkg.sv
hw/comp4Max.sv
maxTree/maxMetricTree.sv
hw/metricBank.sv
hw/maxMetricTop.sv
test/maxMetricTb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = maxMetricTb
FILELIST  = filelist.f
OBJDIR    = obj_dir
SIM       = $(OBJDIR)/V$(TOP)
PASSMSG   = Testbench passed

# sources come from the file list, include dirs are filtered out
SOURCES   = $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS   = test/maxMetricModel.svh

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASSMSG)"

clean:
	rm -rf $(OBJDIR)
